//--- logic/fifo_pkg.sv
package fifo_pkg;

	//////////////////////////////////////////////////
	// widths and depths
	//////////////////////////////////////////////////

	localparam int wide_width = 36; // channel 0 push word.
	localparam int half_width = 18; // pop word, channel 1 push word.

	localparam int store_depth = 512; // 36-bit words per channel.
	localparam int rd_depth = 1024; // capacity in pop words.

	// fill level counts 0 through rd_depth.
	localparam int level_width = 11;

	// pointers in pop-word units, storage index in words.
	localparam int addr_width = $clog2(rd_depth);
	localparam int word_addr_width = $clog2(store_depth);

	// band edge for the almost flags and flag code 1.
	localparam int almost_gap = 4;

	//////////////////////////////////////////////////
	// flag codes
	//////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		push_full       = 4'd0,
		push_almost     = 4'd1,
		push_below_half = 4'd2,
		push_half_free  = 4'd3
	} push_flag_e;

	typedef enum logic [3:0]
	{
		pop_empty      = 4'd0,
		pop_almost     = 4'd1,
		pop_below_half = 4'd2,
		pop_half_full  = 4'd3
	} pop_flag_e;

endpackage

//--- logic/fifo_mem_if.sv
interface fifo_mem_if;

	logic wr_en;
	logic [fifo_pkg::addr_width-1:0] wr_addr; // pop-word units.
	logic rd_en;
	logic rd_clr; // clears the read register.
	logic [fifo_pkg::addr_width-1:0] rd_addr;

	modport ctrl
	(
		output wr_en, wr_addr, rd_en, rd_clr, rd_addr
	);

	modport store
	(
		input wr_en, wr_addr, rd_en, rd_clr, rd_addr
	);

endinterface

//--- logic/fifo_ctrl.sv
module fifo_ctrl
#(
	parameter int rd_ratio = 2 // pop words per push word.
)
(
	input logic fifo_clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic flush,
	fifo_mem_if.ctrl mem,
	output fifo_pkg::push_flag_e push_flag,
	output fifo_pkg::pop_flag_e pop_flag,
	output logic almost_full,
	output logic almost_empty
);

	typedef logic [fifo_pkg::level_width-1:0] level_t;
	typedef logic [fifo_pkg::addr_width-1:0] addr_t;

	localparam level_t full_level = level_t'(fifo_pkg::rd_depth);
	localparam level_t push_step = level_t'(rd_ratio);
	localparam level_t ratio_div = level_t'(rd_ratio);
	localparam level_t gap = level_t'(fifo_pkg::almost_gap);
	localparam level_t half_push = level_t'(fifo_pkg::rd_depth / rd_ratio / 2);
	localparam level_t half_pop = level_t'(fifo_pkg::rd_depth / 2);
	localparam addr_t wr_step = addr_t'(rd_ratio);

	level_t level;
	level_t level_next;
	level_t free_push;
	addr_t wr_ptr;
	addr_t rd_ptr;
	logic push_ok;
	logic pop_ok;

	// free push words, rounded down for the packed channel.
	assign free_push = (full_level - level) / ratio_div;

	assign push_ok = push && (free_push != '0);
	assign pop_ok = pop && (level != '0);

	//////////////////////////////////////////////////
	// pointers and fill level
	//////////////////////////////////////////////////

	always_comb
	begin
		level_next = level;
		if (push_ok)
			level_next = level_next + push_step;
		if (pop_ok)
			level_next = level_next - level_t'(1);
	end

	always_ff @(posedge fifo_clk)
	begin
		if (reset || flush)
		begin
			level <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			level <= level_next;
			if (push_ok)
				wr_ptr <= wr_ptr + wr_step;
			if (pop_ok)
				rd_ptr <= rd_ptr + addr_t'(1);
		end
	end

	// flush wins, storage and dout stay put.
	assign mem.wr_en = push_ok && !flush;
	assign mem.rd_en = pop_ok && !flush;
	assign mem.rd_clr = reset;
	assign mem.wr_addr = wr_ptr;
	assign mem.rd_addr = rd_ptr;

	//////////////////////////////////////////////////
	// flags
	//////////////////////////////////////////////////

	always_comb
	begin
		if (free_push == '0)
			push_flag = fifo_pkg::push_full;
		else if (free_push <= gap)
			push_flag = fifo_pkg::push_almost;
		else if (free_push < half_push)
			push_flag = fifo_pkg::push_below_half;
		else
			push_flag = fifo_pkg::push_half_free;

		if (level == '0)
			pop_flag = fifo_pkg::pop_empty;
		else if (level <= gap)
			pop_flag = fifo_pkg::pop_almost;
		else if (level < half_pop)
			pop_flag = fifo_pkg::pop_below_half;
		else
			pop_flag = fifo_pkg::pop_half_full;
	end

	assign almost_full = (free_push != '0) && (free_push <= gap);
	assign almost_empty = (level != '0) && (level <= gap);

endmodule

//--- logic/fifo_store.sv
module fifo_store
#(
	// 1: a push fills a whole word; 0: pushes fill halves.
	parameter bit split_read = 1'b1
)
(
	input logic fifo_clk,
	input logic [fifo_pkg::wide_width-1:0] din,
	fifo_mem_if.store mem,
	output logic [fifo_pkg::half_width-1:0] dout
);

	localparam int hw = fifo_pkg::half_width;
	localparam int ww = fifo_pkg::wide_width;

	logic [ww-1:0] ram [fifo_pkg::store_depth];
	logic [fifo_pkg::word_addr_width-1:0] wr_word;
	logic [fifo_pkg::word_addr_width-1:0] rd_word;
	logic [ww-1:0] rd_data;

	// upper address bits pick the word, bit 0 the half.
	assign wr_word = mem.wr_addr[fifo_pkg::addr_width-1:1];
	assign rd_word = mem.rd_addr[fifo_pkg::addr_width-1:1];

	//////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////

	always_ff @(posedge fifo_clk)
	begin
		if (mem.wr_en)
		begin
			if (split_read)
				ram[wr_word] <= din; // lower half pops first.
			else if (mem.wr_addr[0])
				ram[wr_word][ww-1:hw] <= din[hw-1:0];
			else
				ram[wr_word][hw-1:0] <= din[hw-1:0];
		end
	end

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////

	assign rd_data = ram[rd_word];

	// loaded on the pop edge, held until the next pop.
	always_ff @(posedge fifo_clk)
	begin
		if (mem.rd_clr)
			dout <= '0;
		else if (mem.rd_en)
		begin
			if (mem.rd_addr[0])
				dout <= rd_data[ww-1:hw];
			else
				dout <= rd_data[hw-1:0];
		end
	end

endmodule

//--- logic/fifo_16k_blk.sv
module fifo_16k_blk
(
	input logic fifo_clk,
	input logic reset,

	// channel 0, 36 in and 18 out.
	input logic [35:0] din0,
	input logic push0,
	input logic pop0,
	input logic flush0,
	output logic [17:0] dout0,
	output fifo_pkg::push_flag_e push_flag0,
	output fifo_pkg::pop_flag_e pop_flag0,
	output logic almost_full0,
	output logic almost_empty0,

	// channel 1, 18 in and 18 out.
	input logic [17:0] din1,
	input logic push1,
	input logic pop1,
	input logic flush1,
	output logic [17:0] dout1,
	output fifo_pkg::push_flag_e push_flag1,
	output fifo_pkg::pop_flag_e pop_flag1,
	output logic almost_full1,
	output logic almost_empty1
);

	fifo_mem_if mem0 ();
	fifo_mem_if mem1 ();

	//////////////////////////////////////////////////
	// channel 0
	//////////////////////////////////////////////////

	fifo_ctrl #(.rd_ratio(2)) ctrl0
	(
		.fifo_clk     (fifo_clk),
		.reset        (reset),
		.push         (push0),
		.pop          (pop0),
		.flush        (flush0),
		.mem          (mem0.ctrl),
		.push_flag    (push_flag0),
		.pop_flag     (pop_flag0),
		.almost_full  (almost_full0),
		.almost_empty (almost_empty0)
	);

	fifo_store #(.split_read(1'b1)) store0
	(
		.fifo_clk (fifo_clk),
		.din      (din0),
		.mem      (mem0.store),
		.dout     (dout0)
	);

	//////////////////////////////////////////////////
	// channel 1
	//////////////////////////////////////////////////

	fifo_ctrl #(.rd_ratio(1)) ctrl1
	(
		.fifo_clk     (fifo_clk),
		.reset        (reset),
		.push         (push1),
		.pop          (pop1),
		.flush        (flush1),
		.mem          (mem1.ctrl),
		.push_flag    (push_flag1),
		.pop_flag     (pop_flag1),
		.almost_full  (almost_full1),
		.almost_empty (almost_empty1)
	);

	fifo_store #(.split_read(1'b0)) store1
	(
		.fifo_clk (fifo_clk),
		.din      ({{(fifo_pkg::wide_width - fifo_pkg::half_width){1'b0}}, din1}),
		.mem      (mem1.store),
		.dout     (dout1)
	);

endmodule

//--- test/fifo_props.sv
module fifo_props
(
	input logic fifo_clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic flush,
	input logic [fifo_pkg::level_width-1:0] level,
	input fifo_pkg::push_flag_e push_flag,
	input fifo_pkg::pop_flag_e pop_flag
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [fifo_pkg::level_width-1:0] level_t;

	localparam level_t full_level = level_t'(fifo_pkg::rd_depth);

	level_bound: assert property (@(posedge fifo_clk) disable iff (reset) level <= full_level)
		else $error("fill level above channel capacity");

	// a push into a full channel is dropped.
	full_hold: assert property (@(posedge fifo_clk) disable iff (reset)
		(push_flag == fifo_pkg::push_full && push && !pop && !flush) |=> $stable(level))
		else $error("fill level moved on a push at full");

	reset_empty: assert property (@(posedge fifo_clk) reset |=> pop_flag == fifo_pkg::pop_empty)
		else $error("pop flag not empty after reset");

endmodule

bind fifo_ctrl fifo_props props
(
	.fifo_clk  (fifo_clk),
	.reset     (reset),
	.push      (push),
	.pop       (pop),
	.flush     (flush),
	.level     (level),
	.push_flag (push_flag),
	.pop_flag  (pop_flag)
);

//--- test/fifo_tb.sv
module fifo_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 10;
	localparam int conv_words = 16;
	localparam int mix_cycles = 400;
	localparam int flush_words = 6;
	localparam int fill_extra = 3; // extra pushes at full and pops at empty.
	localparam int stim_cycles = reset_cycles + 3 * conv_words + 2 * mix_cycles
		+ 4 * (fifo_pkg::rd_depth + 2 * fill_extra) + 4 * flush_words + 50;
	localparam int cycle_limit = 4 * stim_cycles;

	typedef struct packed
	{
		fifo_pkg::push_flag_e push_code;
		fifo_pkg::pop_flag_e pop_code;
		logic almost_full;
		logic almost_empty;
	} flags_t;

	logic fifo_clk;
	logic reset;
	logic [35:0] din0;
	logic push0;
	logic pop0;
	logic flush0;
	logic [17:0] dout0;
	fifo_pkg::push_flag_e push_flag0;
	fifo_pkg::pop_flag_e pop_flag0;
	logic almost_full0;
	logic almost_empty0;
	logic [17:0] din1;
	logic push1;
	logic pop1;
	logic flush1;
	logic [17:0] dout1;
	fifo_pkg::push_flag_e push_flag1;
	fifo_pkg::pop_flag_e pop_flag1;
	logic almost_full1;
	logic almost_empty1;

	logic [17:0] q0 [$]; // pop words in order.
	logic [17:0] q1 [$];
	logic [17:0] exp_dout0;
	logic [17:0] exp_dout1;
	int model_level0;
	int model_level1;
	logic [1:0] seen_almost_full;
	logic [1:0] seen_almost_empty;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;
	int timeouts = 0;
	int cycles = 0;

	fifo_16k_blk dut (.*);

	initial
	begin
		fifo_clk = 1'b0;
		forever #20 fifo_clk = ~fifo_clk;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic int free_words(input int level, input int ratio);
		return (fifo_pkg::rd_depth - level) / ratio;
	endfunction

	function automatic flags_t expect_flags(input int level, input int ratio);
		flags_t f;
		int free;
		free = free_words(level, ratio);
		if (free == 0)
			f.push_code = fifo_pkg::push_full;
		else if (free <= fifo_pkg::almost_gap)
			f.push_code = fifo_pkg::push_almost;
		else if (free < fifo_pkg::rd_depth / ratio / 2)
			f.push_code = fifo_pkg::push_below_half;
		else
			f.push_code = fifo_pkg::push_half_free;
		if (level == 0)
			f.pop_code = fifo_pkg::pop_empty;
		else if (level <= fifo_pkg::almost_gap)
			f.pop_code = fifo_pkg::pop_almost;
		else if (level < fifo_pkg::rd_depth / 2)
			f.pop_code = fifo_pkg::pop_below_half;
		else
			f.pop_code = fifo_pkg::pop_half_full;
		f.almost_full = (free >= 1) && (free <= fifo_pkg::almost_gap);
		f.almost_empty = (level >= 1) && (level <= fifo_pkg::almost_gap);
		return f;
	endfunction

	// inputs read here are the values the DUT samples on this edge.
	always @(posedge fifo_clk)
	begin
		if (reset)
		begin
			q0.delete();
			q1.delete();
			exp_dout0 = '0;
			exp_dout1 = '0;
		end
		else
		begin
			// push and pop both judged on the level before the edge.
			model_level0 = q0.size();
			model_level1 = q1.size();
			if (flush0)
				q0.delete();
			else
			begin
				if (pop0 && model_level0 > 0)
					exp_dout0 = q0.pop_front();
				if (push0 && free_words(model_level0, 2) > 0)
				begin
					q0.push_back(din0[17:0]); // lower half first.
					q0.push_back(din0[35:18]);
				end
			end
			if (flush1)
				q1.delete();
			else
			begin
				if (pop1 && model_level1 > 0)
					exp_dout1 = q1.pop_front();
				if (push1 && free_words(model_level1, 1) > 0)
					q1.push_back(din1);
			end
		end
	end

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [17:0] got, input logic [17:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_channel(input int ch, input int level, input int ratio,
		input fifo_pkg::push_flag_e push_code, input fifo_pkg::pop_flag_e pop_code,
		input logic af, input logic ae, input logic [17:0] dout, input logic [17:0] exp_dout);
		flags_t exp;
		exp = expect_flags(level, ratio);
		check_value($sformatf("push_flag%0d", ch), 18'(push_code), 18'(exp.push_code));
		check_value($sformatf("pop_flag%0d", ch), 18'(pop_code), 18'(exp.pop_code));
		check_value($sformatf("almost_full%0d", ch), 18'(af), 18'(exp.almost_full));
		check_value($sformatf("almost_empty%0d", ch), 18'(ae), 18'(exp.almost_empty));
		check_value($sformatf("dout%0d", ch), dout, exp_dout);
	endtask

	always @(negedge fifo_clk)
	begin
		if (!reset)
		begin
			compare_channel(0, q0.size(), 2, push_flag0, pop_flag0, almost_full0, almost_empty0,
				dout0, exp_dout0);
			compare_channel(1, q1.size(), 1, push_flag1, pop_flag1, almost_full1, almost_empty1,
				dout1, exp_dout1);
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// the other channel idles.
	task automatic drive(input bit ch, input logic push, input logic pop, input logic flush,
		input logic [35:0] din);
		@(posedge fifo_clk);
		push0 <= !ch && push;
		pop0 <= !ch && pop;
		flush0 <= !ch && flush;
		din0 <= din;
		push1 <= ch && push;
		pop1 <= ch && pop;
		flush1 <= ch && flush;
		din1 <= din[17:0];
	endtask

	task automatic fill(input bit ch);
		seen_almost_full[ch] = 1'b0;
		@(negedge fifo_clk);
		while ((ch ? push_flag1 : push_flag0) != fifo_pkg::push_full)
		begin
			if (ch ? almost_full1 : almost_full0)
				seen_almost_full[ch] = 1'b1;
			drive(ch, 1'b1, 1'b0, 1'b0, 36'({$urandom, $urandom}));
			@(negedge fifo_clk);
		end
		repeat (fill_extra)
			drive(ch, 1'b1, 1'b0, 1'b0, 36'({$urandom, $urandom})); // dropped.
		drive(ch, 1'b0, 1'b0, 1'b0, '0);
		assert (seen_almost_full[ch])
		else
		begin
			other_errors++;
			$display("almost_full%0d never went high while the channel filled", ch);
		end
	endtask

	task automatic drain(input bit ch);
		int pops;
		pops = 0;
		seen_almost_empty[ch] = 1'b0;
		@(negedge fifo_clk);
		while ((ch ? pop_flag1 : pop_flag0) != fifo_pkg::pop_empty)
		begin
			if (ch ? almost_empty1 : almost_empty0)
				seen_almost_empty[ch] = 1'b1;
			drive(ch, 1'b0, 1'b1, 1'b0, '0);
			pops++;
			@(negedge fifo_clk);
		end
		repeat (fill_extra)
			drive(ch, 1'b0, 1'b1, 1'b0, '0); // pops at empty leave dout alone.
		drive(ch, 1'b0, 1'b0, 1'b0, '0);
		assert (pops == 0 || seen_almost_empty[ch])
		else
		begin
			other_errors++;
			$display("almost_empty%0d never went high while the channel drained", ch);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other errors %0d, timeouts %0d",
			checks, mismatches, other_errors, timeouts);
		if (mismatches == 0 && other_errors == 0 && timeouts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	initial
	begin
		while (cycles < cycle_limit)
		begin
			@(posedge fifo_clk);
			cycles++;
		end
		timeouts++;
		$display("timeout after %0d cycles, the stimulus did not complete", cycles);
		finish_run();
	end

	initial
	begin
		void'($urandom(32'h8883));
		reset = 1'b1;
		din0 = '0;
		push0 = 1'b0;
		pop0 = 1'b0;
		flush0 = 1'b0;
		din1 = '0;
		push1 = 1'b0;
		pop1 = 1'b0;
		flush1 = 1'b0;
		repeat (reset_cycles) @(posedge fifo_clk);
		reset <= 1'b0;

		// width conversion on channel 0.
		repeat (conv_words)
			drive(1'b0, 1'b1, 1'b0, 1'b0, 36'({$urandom, $urandom}));
		drain(1'b0);

		// interleaved pushes and pops on channel 1.
		repeat (mix_cycles)
			drive(1'b1, 1'($urandom), 1'($urandom), 1'b0, 36'($urandom));
		drain(1'b1);

		fill(1'b0);
		drain(1'b0);
		fill(1'b1);
		drain(1'b1);

		// flush channel 0 with both channels holding data.
		repeat (flush_words)
			drive(1'b0, 1'b1, 1'b0, 1'b0, 36'({$urandom, $urandom}));
		repeat (flush_words)
			drive(1'b1, 1'b1, 1'b0, 1'b0, 36'($urandom));
		drive(1'b0, 1'b0, 1'b0, 1'b1, '0);
		drive(1'b0, 1'b0, 1'b0, 1'b0, '0);
		@(negedge fifo_clk);
		check_value("pop_flag0", 18'(pop_flag0), 18'(fifo_pkg::pop_empty));
		check_value("push_flag0", 18'(push_flag0), 18'(fifo_pkg::push_half_free));
		drain(1'b1);

		repeat (flush_words)
			drive(1'b1, 1'b1, 1'b0, 1'b0, 36'($urandom));
		drive(1'b1, 1'b0, 1'b0, 1'b1, '0);
		drive(1'b1, 1'b0, 1'b0, 1'b0, '0);
		repeat (4) @(posedge fifo_clk);
		finish_run();
	end

endmodule

//--- sim.f
logic/fifo_pkg.sv
logic/fifo_mem_if.sv
logic/fifo_ctrl.sv
logic/fifo_store.sv
logic/fifo_16k_blk.sv
test/fifo_props.sv
test/fifo_tb.sv

//--- run.sh
#!/bin/bash
# builds and runs the testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module fifo_tb \
	-f sim.f -o fifo_sim || { echo "build failed"; exit 1; }

./obj_dir/fifo_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "FAIL, run ended without a verdict"; exit 1; }
echo "PASS"
